// File: qu_pkg.sv
// Shared widths, RV32I encodings, ALU selects and the micro-op format; imported by every design unit.
package qu_pkg;

    // ************************************************************
    // Widths
    // ************************************************************
    localparam int XLEN          = 32;
    localparam int INSTR_W       = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int NUM_REGS      = 32;
    localparam int SHAMT_W       = 5;
    localparam int OPCODE_W      = 7;
    localparam int FUNCT3_W      = 3;
    localparam int ALT_FUNCT_BIT = 30;                 // funct7[5], selects SUB and SRA.

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;

    // ************************************************************
    // Major opcodes
    // ************************************************************
    localparam opcode_t OP_OPCODE      = 7'b0110011;
    localparam opcode_t OP_IMM_OPCODE  = 7'b0010011;
    localparam opcode_t LUI_OPCODE     = 7'b0110111;

    // Not executed by this slice.
    localparam opcode_t LOAD_OPCODE    = 7'b0000011;
    localparam opcode_t STORE_OPCODE   = 7'b0100011;
    localparam opcode_t BRANCH_OPCODE  = 7'b1100011;
    localparam opcode_t JAL_OPCODE     = 7'b1101111;
    localparam opcode_t JALR_OPCODE    = 7'b1100111;
    localparam opcode_t AUIPC_OPCODE   = 7'b0010111;
    localparam opcode_t SYSCALL_OPCODE = 7'b1110011;  // ECALL, EBREAK and CSR access.

    // ************************************************************
    // funct3 codes for OP and OP-IMM
    // ************************************************************
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // ************************************************************
    // ALU selects
    // ************************************************************
    // Operation inside the chosen subunit.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SRL,
        SRA,
        LT,
        LTU,
        XOR,
        OR,
        AND,
        PASS_B
    } alu_op_sel_e;

    // Subunit that drives the ALU result.
    typedef enum logic [1:0] {
        ADDER,
        SHIFT,
        COMP,
        LOGIC
    } alu_res_sel_e;

    // One decoded instruction, 57 bits.
    typedef struct packed {
        reg_addr_t    rd;
        logic         rd_valid;
        reg_addr_t    rs1;
        logic         rs1_valid;
        reg_addr_t    rs2;
        logic         rs2_valid;
        xlen_t        imm;
        logic         imm_valid;
        alu_op_sel_e  alu_op_sel;
        alu_res_sel_e alu_res_sel;
    } uop_t;

endpackage

// File: exec_if.sv
// Operand-filled micro-op passed from the operand stage into the execute stage of the integer core.
`timescale 1ns/1ps

interface exec_if;
    import qu_pkg::*;

    logic  valid;                                     // Micro-op with a writeback.
    logic  illegal;                                   // Unsupported instruction.
    uop_t  uop;
    xlen_t opd1;
    xlen_t opd2;

    modport source (output valid, illegal, uop, opd1, opd2);
    modport sink   (input valid, illegal, uop, opd1, opd2);

endinterface

// File: decode.sv
// Combinational RV32I decoder for OP, OP-IMM and LUI; feeds the operand stage of the integer core.
`timescale 1ns/1ps

module decode
(
    input  qu_pkg::instr_t instr,
    output logic           nop,
    output logic           invalid,
    output qu_pkg::uop_t   uop
);
    import qu_pkg::*;

    opcode_t      opcode;
    funct3_t      funct3;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    xlen_t        imm_i;
    xlen_t        imm_u;
    logic         alt;
    logic         supported;
    alu_op_sel_e  op_sel;
    alu_res_sel_e res_sel;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    // OP-IMM only looks at bit 30 for SRAI; ADDI has no subtract form.
    assign alt = instr[ALT_FUNCT_BIT] && ((opcode == OP_OPCODE) || (funct3 == FUNCT3_SRL_SRA));

    assign supported = (opcode == OP_OPCODE) || (opcode == OP_IMM_OPCODE)
                     || (opcode == LUI_OPCODE);

    assign invalid = !supported;
    assign nop     = supported && (rd == '0);         // Result would be dropped.

    // ************************************************************
    // funct3 to ALU selects, shared by OP and OP-IMM
    // ************************************************************
    always_comb
    begin
        op_sel  = ADD;
        res_sel = ADDER;
        case (funct3)
            FUNCT3_ADD_SUB:
            begin
                op_sel  = alt ? SUB : ADD;
                res_sel = ADDER;
            end
            FUNCT3_SLL:
            begin
                op_sel  = SLL;
                res_sel = SHIFT;
            end
            FUNCT3_SLT:
            begin
                op_sel  = LT;
                res_sel = COMP;
            end
            FUNCT3_SLTU:
            begin
                op_sel  = LTU;
                res_sel = COMP;
            end
            FUNCT3_XOR:
            begin
                op_sel  = XOR;
                res_sel = LOGIC;
            end
            FUNCT3_SRL_SRA:
            begin
                op_sel  = alt ? SRA : SRL;
                res_sel = SHIFT;
            end
            FUNCT3_OR:
            begin
                op_sel  = OR;
                res_sel = LOGIC;
            end
            default:                                  // FUNCT3_AND.
            begin
                op_sel  = AND;
                res_sel = LOGIC;
            end
        endcase
    end

    // ************************************************************
    // Micro-op assembly
    // ************************************************************
    always_comb
    begin
        uop             = '0;
        uop.rd          = rd;
        uop.rs1         = rs1;
        uop.rs2         = rs2;
        uop.alu_op_sel  = op_sel;
        uop.alu_res_sel = res_sel;
        case (opcode)
            OP_OPCODE:
            begin
                uop.rd_valid  = 1'b1;
                uop.rs1_valid = 1'b1;
                uop.rs2_valid = 1'b1;
            end
            OP_IMM_OPCODE:
            begin
                uop.rd_valid  = 1'b1;
                uop.rs1_valid = 1'b1;
                uop.imm       = imm_i;
                uop.imm_valid = 1'b1;
            end
            LUI_OPCODE:
            begin
                uop.rd_valid    = 1'b1;
                uop.imm         = imm_u;
                uop.imm_valid   = 1'b1;
                uop.alu_op_sel  = PASS_B;             // Immediate goes straight through.
                uop.alu_res_sel = LOGIC;
            end
            default:
            begin
                uop.rd = '0;
            end
        endcase
    end

endmodule

// File: regfile.sv
// 32x32 integer register file with two asynchronous read ports and one write port; x0 reads zero.
`timescale 1ns/1ps

module regfile
(
    input  logic              clk,
    input  logic              rst_n,
    input  qu_pkg::reg_addr_t raddr1,
    input  qu_pkg::reg_addr_t raddr2,
    output qu_pkg::xlen_t     rdata1,
    output qu_pkg::xlen_t     rdata2,
    input  logic              we,
    input  qu_pkg::reg_addr_t waddr,
    input  qu_pkg::xlen_t     wdata
);
    import qu_pkg::*;

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // A write in flight is seen by a read in the same cycle.
    assign rdata1 = (raddr1 == '0) ? '0 : (we && (waddr == raddr1)) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (we && (waddr == raddr2)) ? wdata : regs[raddr2];

    no_x0_write_a: assert property (@(posedge clk) disable iff (!rst_n) we |-> (waddr != '0))
        else $error("regfile write to x0");

endmodule

// File: operand_stage.sv
// Operand fetch with execute bypass and immediate select; registers the micro-op into execute.
`timescale 1ns/1ps

module operand_stage
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  qu_pkg::uop_t      uop,
    input  logic              nop,
    input  logic              invalid,
    output qu_pkg::reg_addr_t rf_raddr1,
    output qu_pkg::reg_addr_t rf_raddr2,
    input  qu_pkg::xlen_t     rf_rdata1,
    input  qu_pkg::xlen_t     rf_rdata2,
    input  logic              ex_valid,
    input  qu_pkg::reg_addr_t ex_rd,
    input  qu_pkg::xlen_t     ex_result,
    exec_if.source            ex
);
    import qu_pkg::*;

    xlen_t rs1_val;
    xlen_t rs2_val;
    xlen_t opd1_next;
    xlen_t opd2_next;
    logic  valid_next;
    logic  illegal_next;

    assign rf_raddr1 = uop.rs1;
    assign rf_raddr2 = uop.rs2;

    // Only the instruction in execute can be newer than the register file.
    assign rs1_val = (ex_valid && (ex_rd == uop.rs1)) ? ex_result : rf_rdata1;
    assign rs2_val = (ex_valid && (ex_rd == uop.rs2)) ? ex_result : rf_rdata2;

    assign opd1_next = uop.rs1_valid ? rs1_val : '0;  // LUI adds nothing to B.
    assign opd2_next = uop.imm_valid ? uop.imm : (uop.rs2_valid ? rs2_val : '0);

    assign valid_next   = instr_valid && !invalid && !nop && uop.rd_valid;
    assign illegal_next = instr_valid && invalid;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex.valid   <= 1'b0;
            ex.illegal <= 1'b0;
        end
        else
        begin
            ex.valid   <= valid_next;
            ex.illegal <= illegal_next;
        end
    end

    always_ff @(posedge clk)
    begin
        ex.uop  <= uop;
        ex.opd1 <= opd1_next;
        ex.opd2 <= opd2_next;
    end

    valid_illegal_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex.valid && ex.illegal))
        else $error("exec_if valid and illegal high together");

endmodule

// File: alu.sv
// Integer ALU: adder, shifter, comparator and logic subunits run in parallel, one result is picked.
`timescale 1ns/1ps

module alu
(
    input  qu_pkg::alu_op_sel_e  op_sel,
    input  qu_pkg::alu_res_sel_e res_sel,
    input  qu_pkg::xlen_t        opd_a,
    input  qu_pkg::xlen_t        opd_b,
    output qu_pkg::xlen_t        result
);
    import qu_pkg::*;

    shamt_t shamt;
    xlen_t  adder_res;
    xlen_t  shift_res;
    xlen_t  comp_res;
    xlen_t  logic_res;

    assign shamt = opd_b[SHAMT_W-1:0];                // Upper bits ignored.

    // ************************************************************
    // Subunits
    // ************************************************************
    assign adder_res = (op_sel == SUB) ? (opd_a - opd_b) : (opd_a + opd_b);

    always_comb
    begin
        case (op_sel)
            SRL:     shift_res = opd_a >> shamt;
            SRA:     shift_res = xlen_t'($signed(opd_a) >>> shamt);
            default: shift_res = opd_a << shamt;
        endcase
    end

    always_comb
    begin
        comp_res = '0;
        if (op_sel == LTU)
            comp_res[0] = opd_a < opd_b;
        else
            comp_res[0] = $signed(opd_a) < $signed(opd_b);
    end

    always_comb
    begin
        case (op_sel)
            XOR:     logic_res = opd_a ^ opd_b;
            OR:      logic_res = opd_a | opd_b;
            PASS_B:  logic_res = opd_b;               // LUI.
            default: logic_res = opd_a & opd_b;
        endcase
    end

    // ************************************************************
    // Result select
    // ************************************************************
    always_comb
    begin
        case (res_sel)
            SHIFT:   result = shift_res;
            COMP:    result = comp_res;
            LOGIC:   result = logic_res;
            default: result = adder_res;
        endcase
    end

endmodule

// File: execute_stage.sv
// Execute stage: runs the ALU on the registered micro-op, drives the bypass and the writeback.
`timescale 1ns/1ps

module execute_stage
(
    input  logic              clk,
    input  logic              rst_n,
    exec_if.sink              ex,
    output logic              ex_valid,
    output qu_pkg::reg_addr_t ex_rd,
    output qu_pkg::xlen_t     ex_result,
    output logic              wb_valid,
    output qu_pkg::reg_addr_t wb_rd,
    output qu_pkg::xlen_t     wb_data,
    output logic              illegal_instr
);
    import qu_pkg::*;

    xlen_t alu_result;

    alu alu_inst
    (
        .op_sel  (ex.uop.alu_op_sel),
        .res_sel (ex.uop.alu_res_sel),
        .opd_a   (ex.opd1),
        .opd_b   (ex.opd2),
        .result  (alu_result)
    );

    // Bypass back to the operand stage.
    assign ex_valid  = ex.valid;
    assign ex_rd     = ex.uop.rd;
    assign ex_result = alu_result;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_valid      <= 1'b0;
            illegal_instr <= 1'b0;
        end
        else
        begin
            wb_valid      <= ex.valid;
            illegal_instr <= ex.illegal;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= ex.uop.rd;
        wb_data <= alu_result;
    end

    wb_rd_nonzero_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd != '0))
        else $error("writeback to x0, wb_rd=%h", wb_rd);

endmodule

// File: qu_int_core.sv
// Top level of the RV32I integer execution slice: decoder, operand stage, register file, execute.
`timescale 1ns/1ps

module qu_int_core
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  qu_pkg::instr_t    instr,
    output logic              wb_valid,
    output qu_pkg::reg_addr_t wb_rd,
    output qu_pkg::xlen_t     wb_data,
    output logic              illegal_instr
);
    import qu_pkg::*;

    uop_t      uop;
    logic      nop;
    logic      invalid;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    xlen_t     rf_rdata1;
    xlen_t     rf_rdata2;
    logic      ex_valid;
    reg_addr_t ex_rd;
    xlen_t     ex_result;

    exec_if ex_bus ();

    decode decode_inst
    (
        .instr   (instr),
        .nop     (nop),
        .invalid (invalid),
        .uop     (uop)
    );

    regfile regfile_inst
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    operand_stage operand_stage_inst
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .uop         (uop),
        .nop         (nop),
        .invalid     (invalid),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .ex          (ex_bus.source)
    );

    execute_stage execute_stage_inst
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex            (ex_bus.sink),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal_instr (illegal_instr)
    );

endmodule

// File: tb_qu_int_core.sv
// Self-checking testbench for the integer core; drives RV32I instructions and checks every result pulse.
`timescale 1ns/1ps

module tb_qu_int_core;

    localparam int DRV     = 10;                       // Drive delay after the rising edge.
    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal_instr;

    // Expectation for the instruction being driven, delayed two edges to line up with the outputs.
    logic        exp_wb, p1_wb, p2_wb;
    logic        exp_ill, p1_ill, p2_ill;
    logic [4:0]  exp_rd, p1_rd, p2_rd;
    logic [31:0] exp_data, p1_data, p2_data;

    logic [31:0] shadow [32];
    integer      seed = 32'hf1b2;
    int          errors = 0;
    int          test_base = 0;
    int          tests_run = 0;
    int          exp_pulses = 0;
    int          seen_pulses = 0;

    qu_int_core qu_int_core_inst
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal_instr (illegal_instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            {p1_wb, p1_ill, p2_wb, p2_ill} <= '0;
            seen_pulses <= 0;
        end
        else
        begin
            {p1_wb, p1_ill, p1_rd, p1_data} <= {exp_wb, exp_ill, exp_rd, exp_data};
            {p2_wb, p2_ill, p2_rd, p2_data} <= {p1_wb, p1_ill, p1_rd, p1_data};
            if (wb_valid || illegal_instr)
                seen_pulses <= seen_pulses + 1;
        end
    end

    // ************************************************************
    // Checks
    // ************************************************************
    wb_valid_a: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == p2_wb)
        else begin
            errors++;
            $display("FAILED wb_valid: got %h, expected %h", $sampled(wb_valid), $sampled(p2_wb));
        end
    wb_rd_a: assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> wb_rd == p2_rd)
        else begin
            errors++;
            $display("FAILED wb_rd: got %h, expected %h", $sampled(wb_rd), $sampled(p2_rd));
        end
    wb_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_data == p2_data)
        else begin
            errors++;
            $display("FAILED wb_data: got %h, expected %h", $sampled(wb_data), $sampled(p2_data));
        end
    illegal_a: assert property (@(posedge clk) disable iff (!rst_n) illegal_instr == p2_ill)
        else begin
            errors++;
            $display("FAILED illegal_instr: got %h, expected %h",
                     $sampled(illegal_instr), $sampled(p2_ill));
        end

    // ************************************************************
    // Reference model and stimulus
    // ************************************************************
    function automatic logic [31:0] rv_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic issue(input logic [31:0] ins, input logic legal, input logic [4:0] rd,
                         input logic [31:0] res);
        @(posedge clk);
        #DRV;
        instr_valid = 1'b1;
        instr       = ins;
        exp_wb      = legal && (rd != 5'd0);           // Writes to x0 are dropped.
        exp_ill     = !legal;
        exp_rd      = rd;
        exp_data    = res;
        if (exp_wb || exp_ill)
            exp_pulses++;
        if (exp_wb)
            shadow[rd] = res;
    endtask

    task automatic op_r(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, 1'b1, rd,
              rv_result(f3, alt, shadow[rs1], shadow[rs2]));
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];                 // SRAI.
        issue({imm, rs1, f3, rd, 7'b0010011}, 1'b1, rd,
              rv_result(f3, alt, shadow[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic op_lui(input logic [4:0] rd, input logic [19:0] imm);
        issue({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'b0});
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            #DRV;
            instr_valid = 1'b0;
            exp_wb      = 1'b0;
            exp_ill     = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while ((seen_pulses < exp_pulses) && (n < TIMEOUT))
        begin
            idle(1);
            n++;
        end
        if (seen_pulses < exp_pulses)
        begin
            $display("%s: timed out, %0d of %0d result pulses seen", name, seen_pulses,
                     exp_pulses);
            $display("Simulation failed");
            $finish;
        end
        idle(3);                                       // Window for stray pulses.
        $display("%s: %s", name, (errors == test_base) ? "passed" : "had errors");
        test_base = errors;
        tests_run++;
    endtask

    initial
    begin
        logic [31:0] r;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        {exp_wb, exp_ill, exp_rd, exp_data} = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (3) @(posedge clk);
        #DRV;
        rst_n = 1'b1;

        idle(6);
        finish_test("reset_idle");

        for (int i = 1; i <= 4; i++)
        begin
            r = $random(seed);
            op_lui(5'(i), (i == 3) ? {1'b1, r[18:0]} : r[19:0]);
            r = $random(seed);
            op_i(3'd0, 5'(i), 5'(i), r[11:0]);
        end
        op_r(1'b0, 3'd0, 5'd10, 5'd1, 5'd2);
        op_r(1'b1, 3'd0, 5'd11, 5'd1, 5'd2);
        op_r(1'b0, 3'd1, 5'd12, 5'd1, 5'd2);
        op_r(1'b0, 3'd2, 5'd13, 5'd3, 5'd1);
        op_r(1'b0, 3'd3, 5'd14, 5'd3, 5'd1);
        op_r(1'b0, 3'd4, 5'd15, 5'd1, 5'd2);
        op_r(1'b0, 3'd5, 5'd16, 5'd3, 5'd2);
        op_r(1'b1, 3'd5, 5'd17, 5'd3, 5'd2);
        op_r(1'b0, 3'd6, 5'd18, 5'd1, 5'd4);
        op_r(1'b0, 3'd7, 5'd19, 5'd1, 5'd4);
        finish_test("r_type");

        for (int f = 0; f < 8; f++)
        begin
            r = $random(seed);
            if (f == 1)
                op_i(3'd1, 5'd20, 5'd3, {7'b0, r[4:0]});
            else if (f == 5)
                op_i(3'd5, 5'd21, 5'd3, {7'b0, r[4:0]});
            else
                op_i(3'(f), 5'(22 + f), 5'd1, {1'b1, r[10:0]});
        end
        r = $random(seed);
        op_i(3'd5, 5'd20, 5'd3, {7'b0100000, r[4:0]});
        op_i(3'd2, 5'd21, 5'd3, r[11:0]);
        finish_test("i_type");

        r = $random(seed);
        op_i(3'd0, 5'd5, 5'd1, r[11:0]);               // Each reads the one before.
        op_r(1'b0, 3'd0, 5'd6, 5'd5, 5'd5);
        op_r(1'b1, 3'd0, 5'd7, 5'd6, 5'd5);
        op_r(1'b0, 3'd4, 5'd8, 5'd7, 5'd6);
        op_r(1'b0, 3'd1, 5'd9, 5'd8, 5'd5);
        op_r(1'b0, 3'd6, 5'd5, 5'd9, 5'd6);
        finish_test("bypass");

        op_i(3'd0, 5'd0, 5'd1, 12'h123);
        op_r(1'b0, 3'd0, 5'd0, 5'd1, 5'd2);
        op_lui(5'd0, 20'hfffff);
        op_r(1'b0, 3'd0, 5'd23, 5'd0, 5'd1);
        op_r(1'b0, 3'd6, 5'd24, 5'd0, 5'd0);
        finish_test("x0_writes");

        issue(32'h0000_2083, 1'b0, 5'd0, '0);          // LW x1, 0(x0).
        issue(32'h0011_2023, 1'b0, 5'd0, '0);          // SW.
        issue(32'h0020_8063, 1'b0, 5'd0, '0);          // BEQ.
        issue(32'h0040_00ef, 1'b0, 5'd0, '0);          // JAL x1.
        issue(32'h0000_1097, 1'b0, 5'd0, '0);          // AUIPC x1.
        issue(32'h3000_20f3, 1'b0, 5'd0, '0);          // CSRRS x1.
        r = $random(seed);
        issue({r[31:7], 7'b1111111}, 1'b0, 5'd0, '0);
        op_r(1'b0, 3'd0, 5'd25, 5'd1, 5'd0);
        finish_test("illegal");

        $display("%0d tests run, %0d errors, %0d result pulses", tests_run, errors, seen_pulses);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: project.f
qu_pkg.sv
exec_if.sv
decode.sv
regfile.sv
operand_stage.sv
alu.sv
execute_stage.sv
qu_int_core.sv
tb_qu_int_core.sv
